// File: debugPkg.sv
package debugPkg;

	// ########################################
	// Widths
	// ########################################
	localparam int dataWidth = 16; // CPU word
	localparam int addrWidth = 16; // Byte address, bit 0 always zero
	localparam int hostWidth = 8; // Host pin bus
	localparam int memDepth = 256; // Words of debug memory
	localparam int regCount = 16; // Register file entries
	localparam int reqBit = 2; // Mode byte bit that asks for execution

	// ########################################
	// Encodings
	// ########################################

	// Host register map on the 3-bit addr pins
	typedef enum logic [2:0] {
		regMode = 3'd0, // Bit 0 debug mode, bit 1 stop, bit reqBit request
		regOp = 3'd1, // Bits 3..1 operation, bit 0 autoincrement
		regDataL = 3'd2,
		regDataH = 3'd3, // Also the high byte of the read register
		regAddrL = 3'd4,
		regAddrH = 3'd5
	} debugReg;

	// Operation field of the op register
	typedef enum logic [2:0] {
		opNop = 3'd0, // Acknowledge only
		opMemRead = 3'd1,
		opMemWrite = 3'd2,
		opRegRead = 3'd3,
		opRegWrite = 3'd4,
		opPcLoad = 3'd5,
		opPcRead = 3'd6, // Returns pc plus one
		opCcRead = 3'd7
	} debugOp;

	// Source feeding the read register
	typedef enum logic [1:0] {
		selMem = 2'd0,
		selReg = 2'd1,
		selCc = 2'd2,
		selPcNext = 2'd3
	} debugDataSel;

endpackage

// File: strobeSync.sv
`timescale 1ns/1ps

module strobeSync (
	input  logic                           CLK,
	input  logic                           rst,
	input  logic                           wrn, // Host write strobe, active low
	input  logic                           sel, // This register is addressed
	input  logic [debugPkg::hostWidth-1:0] d,
	output logic [debugPkg::hostWidth-1:0] q,
	output logic                           ld // One cycle when q takes a new byte
);
	import debugPkg::*;

	logic [hostWidth-1:0] hold; // Byte caught on the strobe edge
	logic                 selHit; // Addressed on the most recent strobe
	logic [2:0]           wrnSync; // Two sync flops plus edge history
	logic                 wrnRise; // Synchronized strobe went high

	// ########################################
	// Host strobe domain
	// ########################################
	always_ff @(posedge wrn) begin
		if (sel) begin
			hold <= d; // Only our own register writes replace the byte
		end
		selHit <= sel;
	end

	// ########################################
	// CLK domain
	// ########################################
	assign wrnRise = wrnSync[1] & ~wrnSync[2]; // Valid 2 cycles after wrn rises

	always_ff @(posedge CLK) begin
		if (rst) begin
			wrnSync <= 3'b111; // Strobe idles high
			q <= '0;
			ld <= 1'b0;
		end else begin
			wrnSync <= {wrnSync[1:0], wrn}; // Strobe level crosses here
			ld <= wrnRise & selHit; // Third edge after wrn rises
			if (wrnRise & selHit) begin
				q <= hold; // Stable by now, the strobe edge is long past
			end
		end
	end

	// The captured byte must not move until the strobe level has fully
	// crossed, so a second write may not follow within the sync window
	assert property (@(posedge CLK) disable iff (rst)
		(wrnSync[0] != wrnSync[2]) && selHit |-> $stable(hold));

endmodule

// File: addrCounter.sv
`timescale 1ns/1ps

module addrCounter (
	input  logic                           CLK,
	input  logic                           rst,
	input  logic                           wrn,
	input  logic                           selLow, // Address low byte selected
	input  logic                           selHigh, // Address high byte selected
	input  logic [debugPkg::hostWidth-1:0] d,
	input  logic                           inc, // Step one word
	output logic [debugPkg::addrWidth-1:0] addr
);
	import debugPkg::*;

	logic [hostWidth-1:0] lowQ; // Synchronized low byte
	logic [hostWidth-1:0] highQ; // Synchronized high byte
	logic                 lowLd;
	logic                 highLd;
	logic [addrWidth-2:0] wordAddr; // 15-bit word address

	strobeSync lowSync_i (
		.CLK(CLK),
		.rst(rst),
		.wrn(wrn),
		.sel(selLow),
		.d(d),
		.q(lowQ),
		.ld(lowLd)
	);

	strobeSync highSync_i (
		.CLK(CLK),
		.rst(rst),
		.wrn(wrn),
		.sel(selHigh),
		.d(d),
		.q(highQ),
		.ld(highLd)
	);

	always_ff @(posedge CLK) begin
		if (rst) begin
			wordAddr <= '0;
		end else if (inc) begin
			wordAddr <= wordAddr + 1'b1; // Carry runs into the high half
		end else begin
			if (lowLd) begin
				wordAddr[6:0] <= lowQ[hostWidth-1:1]; // Byte bit 0 dropped
			end
			if (highLd) begin
				wordAddr[addrWidth-2:7] <= highQ;
			end
		end
	end

	assign addr = {wordAddr, 1'b0}; // Byte address of the word

	// Host may only reload the address while no operation is retiring
	assert property (@(posedge CLK) disable iff (rst)
		(lowLd || highLd) |-> !inc);

endmodule

// File: requestGenerator.sv
`timescale 1ns/1ps

module requestGenerator (
	input  logic CLK,
	input  logic rst,
	input  logic wrn,
	input  logic modeWrite, // Mode register addressed
	input  logic dataHighWrite, // Data high register addressed
	input  logic reqFlag, // Request bit of the host byte
	input  logic autoInc, // Autoincrement flag of the op register
	input  logic ack, // Executor finished
	output logic req
);

	logic       trig; // Last strobe was a qualifying write
	logic [2:0] wrnSync; // Two sync flops plus edge history
	logic       wrnRise;

	// ########################################
	// Trigger capture on the host strobe
	// ########################################
	always_ff @(posedge wrn) begin
		// Mode write with request, or streaming data high write
		trig <= (modeWrite & reqFlag) | (dataHighWrite & autoInc);
	end

	// ########################################
	// Request level in CLK domain
	// ########################################
	assign wrnRise = wrnSync[1] & ~wrnSync[2];

	always_ff @(posedge CLK) begin
		if (rst) begin
			wrnSync <= 3'b111; // Strobe idles high
			req <= 1'b0;
		end else begin
			wrnSync <= {wrnSync[1:0], wrn};
			if (ack) begin
				req <= 1'b0; // Drops the cycle after ack
			end else if (wrnRise & trig) begin
				req <= 1'b1; // 3 cycles after wrn rises, no effect if already high
			end
		end
	end

	// Executor only answers a pending request
	assert property (@(posedge CLK) disable iff (rst) ack |-> req);

endmodule

// File: debugPort.sv
`timescale 1ns/1ps

module debugPort (
	// Host pins
	input  logic [debugPkg::hostWidth-1:0] din,
	output logic [debugPkg::hostWidth-1:0] dout,
	input  logic [2:0]                     addr,
	input  logic                           rdn,
	input  logic                           wrn,

	input  logic                           CLK,
	input  logic                           rst,

	// Toward the executor
	output logic                           debugMode,
	output logic                           stopCpu,
	output debugPkg::debugOp               debugOp,
	output logic                           autoInc,
	output logic [debugPkg::addrWidth-1:0] debugAddr,
	output logic [3:0]                     argX,
	output logic [debugPkg::dataWidth-1:0] debugData,
	output logic                           req,

	// From the executor
	input  logic                           ldDataEn,
	input  debugPkg::debugDataSel          dataSel,
	input  logic [debugPkg::dataWidth-1:0] memData,
	input  logic [debugPkg::dataWidth-1:0] regData,
	input  logic [debugPkg::dataWidth-1:0] ccData,
	input  logic [debugPkg::dataWidth-1:0] pcNext,
	input  logic                           addrIncEn,
	input  logic                           ack
);
	import debugPkg::*;

	debugReg              regSel; // Decoded addr pins
	logic                 selMode;
	logic                 selOp;
	logic                 selDataL;
	logic                 selDataH;
	logic                 selAddrL;
	logic                 selAddrH;
	logic [hostWidth-1:0] modeQ; // Mode byte in CLK domain
	logic [hostWidth-1:0] opQ; // Op byte in CLK domain
	logic [hostWidth-1:0] dataLQ;
	logic [hostWidth-1:0] dataHQ;
	logic [dataWidth-1:0] dataMux; // Selected executor source
	logic [dataWidth-1:0] readReg; // Host read-back word

	// ########################################
	// Register select decode
	// ########################################
	assign regSel = debugReg'(addr);
	assign selMode = (regSel == regMode);
	assign selOp = (regSel == regOp);
	assign selDataL = (regSel == regDataL);
	assign selDataH = (regSel == regDataH);
	assign selAddrL = (regSel == regAddrL);
	assign selAddrH = (regSel == regAddrH); // Codes 6 and 7 select nothing

	// ########################################
	// Host registers
	// ########################################
	strobeSync modeSync_i (
		.CLK(CLK), .rst(rst), .wrn(wrn), .sel(selMode), .d(din), .q(modeQ), .ld()
	);

	strobeSync opSync_i (
		.CLK(CLK), .rst(rst), .wrn(wrn), .sel(selOp), .d(din), .q(opQ), .ld()
	);

	strobeSync dataLSync_i (
		.CLK(CLK), .rst(rst), .wrn(wrn), .sel(selDataL), .d(din), .q(dataLQ), .ld()
	);

	strobeSync dataHSync_i (
		.CLK(CLK), .rst(rst), .wrn(wrn), .sel(selDataH), .d(din), .q(dataHQ), .ld()
	);

	addrCounter addrCounter_i (
		.CLK(CLK),
		.rst(rst),
		.wrn(wrn),
		.selLow(selAddrL),
		.selHigh(selAddrH),
		.d(din),
		.inc(addrIncEn), // Autoincrement after a serviced op
		.addr(debugAddr)
	);

	requestGenerator requestGenerator_i (
		.CLK(CLK),
		.rst(rst),
		.wrn(wrn),
		.modeWrite(selMode),
		.dataHighWrite(selDataH),
		.reqFlag(din[reqBit]),
		.autoInc(autoInc),
		.ack(ack),
		.req(req)
	);

	assign debugMode = modeQ[0];
	assign stopCpu = modeQ[1];
	assign debugOp = debugPkg::debugOp'(opQ[3:1]);
	assign autoInc = opQ[0];
	assign debugData = {dataHQ, dataLQ};
	assign argX = debugAddr[4:1]; // Register index rides on the address

	// ########################################
	// Read register and byte read-back
	// ########################################
	always_comb begin
		case (dataSel)
			selMem: dataMux = memData;
			selReg: dataMux = regData;
			selCc: dataMux = ccData;
			selPcNext: dataMux = pcNext;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			readReg <= '0;
		end else if (ldDataEn) begin
			readReg <= dataMux;
		end
	end

	always_comb begin
		if (!rdn && (regSel == regDataH)) begin
			dout = readReg[dataWidth-1:hostWidth]; // High byte
		end else begin
			dout = readReg[hostWidth-1:0]; // Low byte for every other address
		end
	end

endmodule

// File: debugExecutor.sv
`timescale 1ns/1ps

module debugExecutor (
	input  logic                           CLK,
	input  logic                           rst,
	input  logic                           debugMode,
	input  logic                           stopCpu,
	input  debugPkg::debugOp               debugOp,
	input  logic                           autoInc,
	input  logic [debugPkg::addrWidth-1:0] debugAddr,
	input  logic [3:0]                     argX,
	input  logic [debugPkg::dataWidth-1:0] debugData,
	input  logic                           req,
	output logic                           ldDataEn,
	output debugPkg::debugDataSel          dataSel,
	output logic [debugPkg::dataWidth-1:0] memData,
	output logic [debugPkg::dataWidth-1:0] regData,
	output logic [debugPkg::dataWidth-1:0] ccData,
	output logic [debugPkg::dataWidth-1:0] pcNext,
	output logic                           addrIncEn,
	output logic                           ack
);
	import debugPkg::*;

	typedef enum logic [1:0] {idle, exec, done} execState;

	execState             state;
	logic [dataWidth-1:0] mem [memDepth]; // Word memory
	logic [dataWidth-1:0] regFile [regCount];
	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] cc; // Bit 0 zero, bit 1 negative
	logic [7:0]           memIdx; // Word index from the byte address
	logic                 memWrite;
	logic                 regWrite;
	logic                 pcLoad;
	logic [dataWidth-1:0] ccNew; // Flags of the word being written

	assign memIdx = debugAddr[8:1];
	assign memWrite = (state == exec) && (debugOp == opMemWrite);
	assign regWrite = (state == exec) && (debugOp == opRegWrite);
	assign pcLoad = (state == exec) && (debugOp == opPcLoad);
	assign ccNew = {{(dataWidth-2){1'b0}}, debugData[dataWidth-1], debugData == '0};

	// ########################################
	// Request service FSM
	// ########################################
	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= idle;
			ldDataEn <= 1'b0;
			dataSel <= selMem;
			addrIncEn <= 1'b0;
			ack <= 1'b0;
		end else begin
			ldDataEn <= 1'b0; // Pulses by default
			addrIncEn <= 1'b0;
			ack <= 1'b0;
			case (state)
				idle: begin
					if (req && debugMode && stopCpu) begin
						state <= exec; // Only a halted CPU is serviced
					end
				end
				exec: begin
					state <= done;
					ack <= 1'b1; // Same cycle as the action
					addrIncEn <= autoInc;
					case (debugOp)
						opMemRead: begin
							ldDataEn <= 1'b1;
							dataSel <= selMem;
						end
						opRegRead: begin
							ldDataEn <= 1'b1;
							dataSel <= selReg;
						end
						opPcRead: begin
							ldDataEn <= 1'b1;
							dataSel <= selPcNext;
						end
						opCcRead: begin
							ldDataEn <= 1'b1;
							dataSel <= selCc;
						end
						default: begin
							// Nop and writes, the write paths act below
						end
					endcase
				end
				done: state <= idle; // req falls on this edge
				default: state <= idle;
			endcase
		end
	end

	// ########################################
	// CPU state stand-in
	// ########################################
	always_ff @(posedge CLK) begin
		if (memWrite) begin
			mem[memIdx] <= debugData;
		end
		memData <= mem[memIdx]; // Registered read
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int i = 0; i < regCount; i++) begin
				regFile[i] <= '0;
			end
			cc <= '0;
			pc <= '0;
		end else begin
			if (regWrite) begin
				regFile[argX] <= debugData;
			end
			if (memWrite || regWrite) begin
				cc <= ccNew; // Memory and register writes only, not pc load
			end
			if (pcLoad) begin
				pc <= debugData;
			end else if (!stopCpu) begin
				pc <= pc + 1'b1; // Free run while not stopped
			end
		end
	end

	assign regData = regFile[argX];
	assign ccData = cc;
	assign pcNext = pc + 1'b1;

	// Reads only come back from a halted CPU
	assert property (@(posedge CLK) disable iff (rst) ldDataEn |-> stopCpu);

endmodule

// File: debugSubsystem.sv
`timescale 1ns/1ps

module debugSubsystem (
	input  logic                           CLK,
	input  logic                           rst,
	input  logic [debugPkg::hostWidth-1:0] din,
	output logic [debugPkg::hostWidth-1:0] dout,
	input  logic [2:0]                     addr,
	input  logic                           rdn,
	input  logic                           wrn,
	output logic                           req,
	output logic                           debugMode,
	output logic                           stopCpu
);
	import debugPkg::*;

	// ########################################
	// Port to executor nets
	// ########################################
	debugOp               opField;
	logic                 autoInc;
	logic [addrWidth-1:0] debugAddr;
	logic [3:0]           argX;
	logic [dataWidth-1:0] debugData;

	// Executor to port nets
	logic                 ldDataEn;
	debugDataSel          dataSel;
	logic [dataWidth-1:0] memData;
	logic [dataWidth-1:0] regData;
	logic [dataWidth-1:0] ccData;
	logic [dataWidth-1:0] pcNext;
	logic                 addrIncEn;
	logic                 ack;

	debugPort debugPort_i (
		.din(din), .dout(dout), .addr(addr), .rdn(rdn), .wrn(wrn),
		.CLK(CLK), .rst(rst),
		.debugMode(debugMode), .stopCpu(stopCpu), .debugOp(opField),
		.autoInc(autoInc), .debugAddr(debugAddr), .argX(argX),
		.debugData(debugData), .req(req),
		.ldDataEn(ldDataEn), .dataSel(dataSel), .memData(memData),
		.regData(regData), .ccData(ccData), .pcNext(pcNext),
		.addrIncEn(addrIncEn), .ack(ack)
	);

	debugExecutor debugExecutor_i (
		.CLK(CLK), .rst(rst),
		.debugMode(debugMode), .stopCpu(stopCpu), .debugOp(opField),
		.autoInc(autoInc), .debugAddr(debugAddr), .argX(argX),
		.debugData(debugData), .req(req),
		.ldDataEn(ldDataEn), .dataSel(dataSel), .memData(memData),
		.regData(regData), .ccData(ccData), .pcNext(pcNext),
		.addrIncEn(addrIncEn), .ack(ack)
	);

endmodule

// File: debugTb.sv
`timescale 1ns/1ps

module debugTb;
	import debugPkg::*;

	// ########################################
	// Run length
	// ########################################
	localparam int memPairs = 8; // Random write then read pairs
	localparam int streamLen = 8; // Words per autoincrement block
	localparam int regPairs = 4; // Register write, read, cc read rounds
	localparam int checkWindow = 50; // Cycles a stalled request is watched
	localparam int reqLimit = 40; // Cycles allowed for req to fall
	localparam int plannedOps = 3 + memPairs * 10 + 7 + streamLen * 5 + regPairs * 14 + 8 + 5;
	localparam int timeoutNs = (plannedOps * 40 + checkWindow) * 10 + 2000; // Plus margin
	localparam logic [hostWidth-1:0] modeRun = (8'h01 << reqBit) | 8'h03; // Debug, stop, request

	logic                 CLK;
	logic                 rst;
	logic [hostWidth-1:0] din;
	logic [hostWidth-1:0] dout;
	logic [2:0]           addr;
	logic                 rdn;
	logic                 wrn;
	logic                 req;
	logic                 debugMode;
	logic                 stopCpu;

	logic [dataWidth-1:0] refMem [memDepth]; // Shadow of the executor state
	logic [dataWidth-1:0] refReg [regCount];
	logic [dataWidth-1:0] refPc;
	logic [dataWidth-1:0] refCc;

	string                nameQ [$]; // Results waiting for the compare process
	logic [dataWidth-1:0] gotQ [$];
	logic [dataWidth-1:0] expQ [$];
	bit                   isBitQ [$];
	int                   issuedCount;
	int                   doneCount;
	event                 checkPending;

	debugSubsystem debugSubsystem_i (
		.CLK(CLK),
		.rst(rst),
		.din(din),
		.dout(dout),
		.addr(addr),
		.rdn(rdn),
		.wrn(wrn),
		.req(req),
		.debugMode(debugMode),
		.stopCpu(stopCpu)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK; // 10 ns period
	end

	// ########################################
	// Reference model
	// ########################################
	function automatic logic [dataWidth-1:0] ccOf(input logic [dataWidth-1:0] word);
		ccOf = '0;
		ccOf[1] = word[dataWidth-1]; // Negative
		ccOf[0] = (word == '0); // Zero
	endfunction

	function automatic logic [dataWidth-1:0] expectRead(input debugOp op,
			input logic [addrWidth-1:0] byteAddr);
		case (op)
			opMemRead: expectRead = refMem[byteAddr[8:1]]; // Word index
			opRegRead: expectRead = refReg[byteAddr[4:1]]; // argX
			opPcRead: expectRead = refPc + 1'b1;
			opCcRead: expectRead = refCc;
			default: expectRead = 'x;
		endcase
	endfunction

	task automatic applyOp(input debugOp op, input logic [addrWidth-1:0] byteAddr,
			input logic [dataWidth-1:0] word);
		case (op)
			opMemWrite: begin
				refMem[byteAddr[8:1]] = word;
				refCc = ccOf(word);
			end
			opRegWrite: begin
				refReg[byteAddr[4:1]] = word;
				refCc = ccOf(word);
			end
			opPcLoad: refPc = word; // Flags untouched
			default: begin
			end
		endcase
	endtask

	// ########################################
	// Compare side
	// ########################################
	task automatic stopOnFailure(input string why);
		$display(">>> FAIL");
		$fatal(1, "Run stopped: %s", why);
	endtask

	task automatic checkWord(input string name, input logic [dataWidth-1:0] got,
			input logic [dataWidth-1:0] exp);
		if (got !== exp) begin
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
			stopOnFailure("a word did not match its expected value");
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
			stopOnFailure("a status pin did not match its expected value");
		end
	endtask

	task automatic deferCheck(input string name, input logic [dataWidth-1:0] got,
			input logic [dataWidth-1:0] exp, input bit isBit);
		nameQ.push_back(name);
		gotQ.push_back(got);
		expQ.push_back(exp);
		isBitQ.push_back(isBit);
		issuedCount++;
		-> checkPending;
	endtask

	initial begin
		string                name;
		logic [dataWidth-1:0] got;
		logic [dataWidth-1:0] exp;
		bit                   isBit;

		forever begin
			@(checkPending);
			while (gotQ.size() > 0) begin // Drains everything posted this step
				name = nameQ.pop_front();
				got = gotQ.pop_front();
				exp = expQ.pop_front();
				isBit = isBitQ.pop_front();
				if (isBit) begin
					checkBit(name, got[0], exp[0]);
				end else begin
					checkWord(name, got, exp);
				end
				doneCount++;
			end
		end
	end

	// ########################################
	// Host bus
	// ########################################
	task automatic hostWrite(input debugReg sel, input logic [hostWidth-1:0] value);
		@(posedge CLK);
		#1;
		addr = sel;
		din = value;
		wrn = 1'b0;
		repeat (4) @(posedge CLK);
		#1;
		wrn = 1'b1; // Byte taken on this edge
		repeat (4) @(posedge CLK); // addr and din held past the rise
	endtask

	task automatic hostRead(input debugReg sel, output logic [hostWidth-1:0] value);
		@(posedge CLK);
		#1;
		addr = sel;
		rdn = 1'b0;
		@(negedge CLK);
		value = dout; // Settled mid cycle
		@(posedge CLK);
		#1;
		rdn = 1'b1;
	endtask

	task automatic readWord(output logic [dataWidth-1:0] word);
		logic [hostWidth-1:0] hi;
		logic [hostWidth-1:0] lo;

		hostRead(regDataH, hi);
		hostRead(regDataL, lo); // Any other address gives the low byte
		word = {hi, lo};
	endtask

	task automatic awaitReqLow();
		int waited;

		waited = 0;
		@(negedge CLK);
		while (req !== 1'b0 && waited < reqLimit) begin
			@(negedge CLK);
			waited++;
		end
		if (req !== 1'b0) begin
			stopOnFailure("req did not fall after the request was raised");
		end
		@(posedge CLK); // One spare cycle before read-back
	endtask

	task automatic selectOp(input debugOp op, input logic inc);
		hostWrite(regOp, {4'b0000, op, inc});
	endtask

	task automatic pointAt(input logic [addrWidth-1:0] byteAddr);
		hostWrite(regAddrL, byteAddr[7:0]);
		hostWrite(regAddrH, byteAddr[15:8]);
	endtask

	task automatic putData(input logic [dataWidth-1:0] word);
		hostWrite(regDataL, word[7:0]);
		hostWrite(regDataH, word[15:8]); // Starts a request when autoincrement is set
	endtask

	task automatic startOp();
		hostWrite(regMode, modeRun);
		awaitReqLow();
	endtask

	task automatic sampleModePins(input logic expMode, input logic expStop, input logic expReq);
		@(negedge CLK);
		deferCheck("debugMode", 16'(debugMode), 16'(expMode), 1'b1);
		deferCheck("stopCpu", 16'(stopCpu), 16'(expStop), 1'b1);
		deferCheck("req", 16'(req), 16'(expReq), 1'b1);
	endtask

	// ########################################
	// Stimulus
	// ########################################
	initial begin
		logic [addrWidth-2:0] wordIdx;
		logic [addrWidth-1:0] byteAddr;
		logic [addrWidth-1:0] curAddr;
		logic [addrWidth-1:0] streamStart;
		logic [dataWidth-1:0] word;
		logic [dataWidth-1:0] got;
		int unsigned          seedInit;

		seedInit = $urandom(65999); // One seed for the whole run
		rst = 1'b1;
		din = '0;
		addr = '0;
		rdn = 1'b1;
		wrn = 1'b1; // Strobes idle high
		issuedCount = 0;
		doneCount = 0;
		refPc = '0;
		refCc = '0;
		for (int i = 0; i < regCount; i++) begin
			refReg[i] = '0;
		end
		repeat (4) @(posedge CLK);
		#1;
		rst = 1'b0;

		// Mode pins after reset and after plain mode writes
		sampleModePins(1'b0, 1'b0, 1'b0);
		hostWrite(regMode, 8'h01);
		sampleModePins(1'b1, 1'b0, 1'b0);
		hostWrite(regMode, 8'h02);
		sampleModePins(1'b0, 1'b1, 1'b0);
		hostWrite(regMode, 8'h03); // Halted session from here on
		sampleModePins(1'b1, 1'b1, 1'b0);

		// Random memory write then read
		for (int i = 0; i < memPairs; i++) begin
			wordIdx = 15'($urandom);
			byteAddr = {wordIdx, 1'b0};
			word = 16'($urandom);
			selectOp(opMemWrite, 1'b0);
			pointAt(byteAddr);
			putData(word);
			startOp();
			applyOp(opMemWrite, byteAddr, word);
			selectOp(opMemRead, 1'b0);
			startOp();
			readWord(got);
			deferCheck("dout memory word", got, expectRead(opMemRead, byteAddr), 1'b0);
		end

		// Autoincrement block across the address byte boundary
		wordIdx = (15'($urandom) & 15'h7f80) | 15'h007c;
		streamStart = {wordIdx, 1'b0};
		curAddr = streamStart;
		selectOp(opMemWrite, 1'b1);
		pointAt(streamStart);
		for (int i = 0; i < streamLen; i++) begin
			word = 16'($urandom);
			putData(word); // Data high write is the trigger
			awaitReqLow();
			applyOp(opMemWrite, curAddr, word);
			curAddr = curAddr + 16'd2;
		end
		selectOp(opMemRead, 1'b1);
		pointAt(streamStart);
		curAddr = streamStart;
		for (int i = 0; i < streamLen; i++) begin
			startOp();
			readWord(got);
			deferCheck("dout stream word", got, expectRead(opMemRead, curAddr), 1'b0);
			curAddr = curAddr + 16'd2;
		end

		// Register file through argX, then the flags
		for (int i = 0; i < regPairs; i++) begin
			byteAddr = {15'($urandom), 1'b0};
			if (i == 0) begin
				word = '0; // Zero flag
			end else if (i == 1) begin
				word = 16'($urandom) | 16'h8000; // Negative flag
			end else begin
				word = 16'($urandom);
			end
			selectOp(opRegWrite, 1'b0);
			pointAt(byteAddr);
			putData(word);
			startOp();
			applyOp(opRegWrite, byteAddr, word);
			selectOp(opRegRead, 1'b0);
			startOp();
			readWord(got);
			deferCheck("dout register word", got, expectRead(opRegRead, byteAddr), 1'b0);
			selectOp(opCcRead, 1'b0);
			startOp();
			readWord(got);
			deferCheck("dout condition codes", got, expectRead(opCcRead, byteAddr), 1'b0);
		end

		// Program counter load and read while halted
		word = 16'($urandom);
		selectOp(opPcLoad, 1'b0);
		putData(word);
		startOp();
		applyOp(opPcLoad, '0, word);
		selectOp(opPcRead, 1'b0);
		startOp();
		readWord(got);
		deferCheck("dout pc next", got, expectRead(opPcRead, '0), 1'b0);

		// Request held while the CPU runs, released by stopping it
		curAddr = streamStart + 16'(2 * (streamLen - 1)); // Last stream word sits past the carry
		selectOp(opMemRead, 1'b0);
		pointAt(curAddr);
		hostWrite(regMode, (8'h01 << reqBit) | 8'h01); // Request without stop
		repeat (checkWindow) begin
			@(negedge CLK);
			deferCheck("req", 16'(req), 16'd1, 1'b1);
		end
		hostWrite(regMode, modeRun); // Second trigger ignored while the stop bit releases it
		awaitReqLow();
		readWord(got);
		deferCheck("dout released read", got, expectRead(opMemRead, curAddr), 1'b0);

		wait (doneCount == issuedCount);
		$display(">>> PASS");
		$finish;
	end

	// Watchdog sized from the planned host traffic
	initial begin
		#(timeoutNs);
		stopOnFailure("the tests did not finish before the watchdog limit");
	end

endmodule

// File: list.f
debugPkg.sv
strobeSync.sv
addrCounter.sv
requestGenerator.sv
debugPort.sv
debugExecutor.sv
debugSubsystem.sv
debugTb.sv

// File: Bender.yml
package:
  name: debug_subsystem

sources:
  - files:
      - debugPkg.sv
      - strobeSync.sv
      - addrCounter.sv
      - requestGenerator.sv
      - debugPort.sv
      - debugExecutor.sv
      - debugSubsystem.sv
  - target: simulation
    files:
      - debugTb.sv
